/* src.f */
common/cfreq_pkg.sv
source/iq_serializer.sv
complex_freq/isqrt.sv
complex_freq/complex_freq.sv
source/status_latch.sv
source/freq_monitor_top.sv
tests/freq_monitor_sva.sv
tests/tb_freq_monitor.sv

/* Makefile */
VERILATOR  = verilator
TOP        = tb_freq_monitor
FILELIST   = src.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = tests failed
COMMON     = --timing --assert --timescale 1ns/1ps
LINT_FLAGS = --lint-only $(COMMON)
SIM_FLAGS  = --binary $(COMMON) -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/tb_freq_monitor.sv */
module tb_freq_monitor;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int refcnt_w = 4;
	localparam int window = 1 << refcnt_w;  // Pairs per reference window
	localparam int drive_delay = 10;

	logic clk;
	logic rst_n;
	cfreq_pkg::sample_t sample_i;
	cfreq_pkg::sample_t sample_q;
	logic sample_strobe;
	logic err_clear;
	logic signed [refcnt_w:0] freq;
	logic freq_valid;
	cfreq_pkg::amp_t amp_max;
	cfreq_pkg::amp_t amp_min;
	logic updated;
	logic err_flag;
	logic [7:0] report_seq;

	// Last window report and the running count of reports
	int upd_total = 0;
	logic signed [refcnt_w:0] cap_freq;
	logic cap_valid;
	cfreq_pkg::amp_t cap_max;
	cfreq_pkg::amp_t cap_min;

	int errors = 0;
	int tests_run = 0;
	int tests_bad = 0;
	int seed = 4;
	cfreq_pkg::sample_t pat_i[$];  // Pairs sent in a cycle
	cfreq_pkg::sample_t pat_q[$];

	freq_monitor_top #(
		.refcnt_w(refcnt_w)
	) i_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.sample_i     (sample_i),
		.sample_q     (sample_q),
		.sample_strobe(sample_strobe),
		.err_clear    (err_clear),
		.freq         (freq),
		.freq_valid   (freq_valid),
		.amp_max      (amp_max),
		.amp_min      (amp_min),
		.updated      (updated),
		.err_flag     (err_flag),
		.report_seq   (report_seq)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		if (updated) begin
			upd_total = upd_total + 1;
			cap_freq = freq;
			cap_valid = freq_valid;
			cap_max = amp_max;
			cap_min = amp_min;
		end
	end

	task automatic step_cycle();
		@(posedge clk);
		#(drive_delay);
	endtask

	function automatic longint int_root(input longint v);
		longint r;
		r = longint'($sqrt(real'(v)));
		while (r * r > v)
			r--;
		while ((r + 1) * (r + 1) <= v)
			r++;
		return r;
	endfunction

	task automatic check_value(input string what, input longint got, input longint exp);
		assert (got == exp) else begin
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - errors_before);
			tests_bad++;
		end
	endtask

	task automatic add_pair(input int i, input int q);
		pat_i.push_back(cfreq_pkg::sample_t'(i));
		pat_q.push_back(cfreq_pkg::sample_t'(q));
	endtask

	// Quadrant 0..3 counted counter-clockwise from the first one
	task automatic add_quadrant(input int quad, input int r);
		case (quad % 4)
			0: add_pair(r, r);
			1: add_pair(-r, r);
			2: add_pair(-r, -r);
			default: add_pair(r, -r);
		endcase
	endtask

	task automatic send_pair(input cfreq_pkg::sample_t i, input cfreq_pkg::sample_t q,
		input int gap);
		sample_i = i;
		sample_q = q;
		sample_strobe = 1'b1;
		step_cycle();
		sample_strobe = 1'b0;
		repeat (gap - 1) step_cycle();
	endtask

	// Cycles through the pattern until n reports came, the last one is checked
	task automatic run_reports(input int n, input string name);
		int start;
		int k;
		start = upd_total;
		k = 0;
		while (upd_total - start < n && k < n * window + 8) begin
			send_pair(pat_i[k % pat_i.size()], pat_q[k % pat_q.size()], 30);
			k++;
		end
		if (upd_total - start < n) begin
			$display("%s: window report missing after %0d pairs", name, k);
			errors++;
		end
	endtask

	task automatic pattern_extremes(output longint mn, output longint mx);
		longint m;
		mn = 1 << 20;
		mx = -1;
		for (int k = 0; k < pat_i.size(); k++) begin
			m = int_root(longint'(pat_i[k]) * longint'(pat_i[k])
				+ longint'(pat_q[k]) * longint'(pat_q[k]));
			if (m < mn)
				mn = m;
			if (m > mx)
				mx = m;
		end
	endtask

	task automatic check_extremes(input string name);
		longint mn;
		longint mx;
		pattern_extremes(mn, mx);
		run_reports(2, name);  // First report may hold older pairs
		check_value("amp_max", longint'(cap_max), mx);
		check_value("amp_min", longint'(cap_min), mn);
	endtask

	task automatic test_magnitude();
		int e0;
		e0 = errors;
		pat_i.delete();
		pat_q.delete();
		add_pair(3000, 4000);
		run_reports(2, "magnitude");
		check_value("amp_max", longint'(cap_max), 5000);
		check_value("amp_min", longint'(cap_min), 5000);
		pat_i.delete();
		pat_q.delete();
		add_pair(-3000, 4000);
		add_pair(3000, -4000);
		add_pair(-3000, -4000);
		run_reports(2, "magnitude");
		check_value("amp_max", longint'(cap_max), 5000);
		check_value("amp_min", longint'(cap_min), 5000);
		end_test("magnitude", e0);
	endtask

	task automatic test_min_max();
		int e0;
		e0 = errors;
		pat_i.delete();
		pat_q.delete();
		add_pair(5, 12);
		add_pair(0, 0);
		add_pair(-8, 15);
		add_pair(131071, 0);
		add_pair(20, -21);
		add_pair(119, 120);
		add_pair(-131071, 0);
		add_pair(696, -697);
		add_pair(33, 56);
		check_extremes("min_max");
		end_test("min_max", e0);
	endtask

	task automatic test_rotation();
		int e0;
		e0 = errors;
		pat_i.delete();
		pat_q.delete();
		for (int k = 0; k < 4; k++)
			add_quadrant(k, 1000);
		run_reports(2, "rotation");
		check_value("freq ccw", longint'(cap_freq), window / 2);  // One quarter turn per pair
		check_value("freq_valid ccw", longint'(cap_valid), 1);
		check_value("amp_max", longint'(cap_max), int_root(2000000));
		pat_i.delete();
		pat_q.delete();
		for (int k = 4; k > 0; k--)
			add_quadrant(k, 1000);
		run_reports(2, "rotation");
		check_value("freq cw", longint'(cap_freq), -(window / 2));
		check_value("freq_valid cw", longint'(cap_valid), 1);
		end_test("rotation", e0);
	endtask

	task automatic test_invalid();
		int e0;
		e0 = errors;
		pat_i.delete();
		pat_q.delete();
		for (int k = 0; k < window; k++)
			add_quadrant((k == 9) ? 2 : k, 2000);  // Q1 straight to Q3 once per cycle
		run_reports(2, "invalid");
		check_value("freq_valid after half turn", longint'(cap_valid), 0);
		pat_i.delete();
		pat_q.delete();
		for (int k = 0; k < 4; k++)
			add_quadrant(k, 2000);
		run_reports(2, "invalid");
		check_value("freq_valid clean window", longint'(cap_valid), 1);
		check_value("freq clean window", longint'(cap_freq), window / 2);
		end_test("invalid", e0);
	endtask

	task automatic test_status();
		int e0;
		int k;
		int seq0;
		e0 = errors;
		check_value("err_flag before error", longint'(err_flag), 0);
		send_pair(18'sd1000, 18'sd1000, 10);
		send_pair(18'sd2000, 18'sd0, 30);  // Lands while the first root runs
		k = 0;
		while (!err_flag && k < 40) begin
			step_cycle();
			k++;
		end
		if (!err_flag) begin
			$display("status: err_flag not set after an early strobe");
			errors++;
		end
		pat_i.delete();
		pat_q.delete();
		add_pair(1500, 1500);
		for (int n = 0; n < 3; n++)
			send_pair(pat_i[0], pat_q[0], 30);
		check_value("err_flag held", longint'(err_flag), 1);
		err_clear = 1'b1;
		step_cycle();
		err_clear = 1'b0;
		check_value("err_flag after clear", longint'(err_flag), 0);
		seq0 = int'(report_seq);
		run_reports(2, "status");
		check_value("report_seq", longint'(report_seq), longint'((seq0 + 2) % 256));
		check_value("report_seq total", longint'(report_seq), longint'(upd_total % 256));
		end_test("status", e0);
	endtask

	task automatic test_random();
		int e0;
		int a;
		int b;
		e0 = errors;
		for (int round = 0; round < 3; round++) begin
			pat_i.delete();
			pat_q.delete();
			for (int k = 0; k < window; k++) begin
				a = $random(seed) % 92682;  // Keeps I^2+Q^2 below 2^34
				b = $random(seed) % 92682;
				add_pair(a, b);
			end
			check_extremes("random");
		end
		end_test("random", e0);
	endtask

	initial begin
		rst_n = 1'b0;
		sample_i = '0;
		sample_q = '0;
		sample_strobe = 1'b0;
		err_clear = 1'b0;
		repeat (3) @(posedge clk);
		#(drive_delay);
		rst_n = 1'b1;
		step_cycle();
		test_magnitude();
		test_min_max();
		test_rotation();
		test_invalid();
		test_status();
		test_random();
		$display("summary: %0d tests run, %0d clean, %0d with errors, %0d check errors",
			tests_run, tests_run - tests_bad, tests_bad, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* tests/freq_monitor_sva.sv */
module freq_monitor_sva (
	input logic clk,
	input logic rst_n,
	input logic sgate,
	input logic en,     // Square-root start from the square-sum stage
	input logic busy,
	input logic dav,
	input logic updated
);

	timeunit 1ns;
	timeprecision 100ps;

	// One I word and one Q word per gate
	gate_two_cycles: assert property (@(posedge clk) disable iff (!rst_n)
		(sgate && $past(sgate)) |-> !$past(sgate, 2))
		else $error("sgate stayed high for more than two cycles");

	// An en that finds the root idle starts it, one arriving during a root is dropped
	dav_after_en: assert property (@(posedge clk) disable iff (!rst_n)
		$past(en && !busy, 18) |-> dav)
		else $error("no dav 18 cycles after en");

	root_started_by_en: assert property (@(posedge clk) disable iff (!rst_n)
		dav |-> $past(en && !busy, 18))
		else $error("dav without an en 18 cycles earlier");

	update_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		$past(updated) |-> !updated)
		else $error("updated high in two cycles in a row");

endmodule

bind complex_freq freq_monitor_sva i_sva (
	.clk    (clk),
	.rst_n  (rst_n),
	.sgate  (sgate),
	.en     (sqrt_en),
	.busy   (busy),
	.dav    (sqrt_dav),
	.updated(updated)
);

/* source/freq_monitor_top.sv */
module freq_monitor_top #(
	parameter int refcnt_w = 17
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  cfreq_pkg::sample_t       sample_i,
	input  cfreq_pkg::sample_t       sample_q,
	input  logic                     sample_strobe,  // At least 24 cycles apart
	input  logic                     err_clear,
	output logic signed [refcnt_w:0] freq,
	output logic                     freq_valid,
	output cfreq_pkg::amp_t          amp_max,
	output cfreq_pkg::amp_t          amp_min,
	output logic                     updated,
	output logic                     err_flag,
	output logic [7:0]               report_seq
);

	// Serial sample bus
	cfreq_pkg::sample_t sdata;
	logic sgate;

	logic timing_err;

	iq_serializer i_serializer (
		.clk          (clk),
		.rst_n        (rst_n),
		.sample_i     (sample_i),
		.sample_q     (sample_q),
		.sample_strobe(sample_strobe),
		.sdata        (sdata),
		.sgate        (sgate)
	);

	complex_freq #(
		.refcnt_w(refcnt_w)
	) i_complex_freq (
		.clk       (clk),
		.rst_n     (rst_n),
		.sdata     (sdata),
		.sgate     (sgate),
		.freq      (freq),
		.freq_valid(freq_valid),
		.amp_max   (amp_max),
		.amp_min   (amp_min),
		.updated   (updated),
		.timing_err(timing_err)
	);

	// Window reports are counted in the status block as well
	status_latch #(
		.refcnt_w(refcnt_w)
	) i_status (
		.clk       (clk),
		.rst_n     (rst_n),
		.timing_err(timing_err),
		.updated   (updated),
		.err_clear (err_clear),
		.err_flag  (err_flag),
		.report_seq(report_seq)
	);

endmodule

/* source/status_latch.sv */
module status_latch #(
	parameter int refcnt_w = 17
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       timing_err,
	input  logic       updated,
	input  logic       err_clear,
	output logic       err_flag,
	output logic [7:0] report_seq
);

	// Report counter, never narrower than the port that shows it
	localparam int seq_w = (refcnt_w > 8) ? refcnt_w : 8;

	logic [seq_w-1:0] seq_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			err_flag <= 1'b0;
			seq_cnt <= '0;
		end else begin
			// A new error in the clearing cycle must not be lost
			if (timing_err)
				err_flag <= 1'b1;
			else if (err_clear)
				err_flag <= 1'b0;
			if (updated)
				seq_cnt <= seq_cnt + 1'b1;
		end
	end

	assign report_seq = seq_cnt[7:0];  // Wraps every 256 reports

endmodule

/* complex_freq/complex_freq.sv */
module complex_freq #(
	parameter int refcnt_w = 17
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  cfreq_pkg::sample_t       sdata,
	input  logic                     sgate,  // Two cycles, I then Q
	output logic signed [refcnt_w:0] freq,
	output logic                     freq_valid,
	output cfreq_pkg::amp_t          amp_max,
	output cfreq_pkg::amp_t          amp_min,
	output logic                     updated,    // One pulse per closed window
	output logic                     timing_err  // Pair arrived while a root was running
);

	localparam int sample_w = cfreq_pkg::sample_w;

	typedef logic signed [2*sample_w-1:0] square_t;

	cfreq_pkg::sample_t sdata_r;  // Multiplier input register
	square_t square;
	square_t square_d;
	cfreq_pkg::square_sum_t sqrt_x;
	logic [1:0] gate_d;
	logic sqrt_en;
	cfreq_pkg::amp_t sqrt_y;
	logic sqrt_dav;
	logic busy;

	logic [refcnt_w-1:0] refcnt;
	logic rollover;
	logic window_end;
	cfreq_pkg::amp_t amp_max_x;  // Developing values of the open window
	cfreq_pkg::amp_t amp_min_x;

	logic i_sign;
	logic [1:0] quad;
	logic [1:0] quad_old;
	logic [1:0] step;
	logic signed [refcnt_w+1:0] quad_cnt;  // Net quarter turns, range +-2^refcnt_w
	logic invalid;

	// One multiplier serves both words of a pair
	always_ff @(posedge clk) begin
		sdata_r <= sdata;
		square <= square_t'(sdata_r) * square_t'(sdata_r);
		square_d <= square;
		sqrt_x <= cfreq_pkg::square_sum_t'(square + square_d);  // Full-scale pairs wrap
	end

	// The sum of a pair is ready one cycle after the delayed gate falls
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gate_d <= '0;
			sqrt_en <= 1'b0;
		end else begin
			gate_d <= {gate_d[0], sgate};
			sqrt_en <= gate_d[1] & ~gate_d[0];
		end
	end

	isqrt #(
		.x_width(cfreq_pkg::sq_w)
	) i_isqrt (
		.clk  (clk),
		.rst_n(rst_n),
		.x    (sqrt_x),
		.en   (sqrt_en),
		.y    (sqrt_y),
		.dav  (sqrt_dav)
	);

	// Only the leading word of a pair is checked against a running root
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			timing_err <= 1'b0;
		end else begin
			if (sqrt_en)
				busy <= 1'b1;
			else if (sqrt_dav)
				busy <= 1'b0;
			timing_err <= busy & sgate & ~gate_d[0];
		end
	end

	// Reference down-counter, counts finished roots
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			refcnt <= refcnt_w'(1);  // First window is short
			rollover <= 1'b0;
		end else begin
			if (sqrt_dav)
				refcnt <= refcnt - 1'b1;
			rollover <= &refcnt;
		end
	end

	assign window_end = sqrt_dav & rollover;

	// The root that closes a window also seeds the next one
	always_ff @(posedge clk) begin
		if (sqrt_dav && (rollover || sqrt_y > amp_max_x))
			amp_max_x <= sqrt_y;
		if (sqrt_dav && (rollover || sqrt_y < amp_min_x))
			amp_min_x <= sqrt_y;
		if (window_end) begin
			amp_max <= amp_max_x;
			amp_min <= amp_min_x;
			freq <= quad_cnt[refcnt_w+1:1];  // Two crossings per turn of a quadrant pair
		end
		if (sgate && !gate_d[0])
			i_sign <= sdata[sample_w-1];
	end

	// Quadrant code counts down as the phasor turns counter-clockwise
	assign step = quad - quad_old;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			quad <= 2'd0;
			quad_old <= 2'd0;
			quad_cnt <= '0;
			invalid <= 1'b0;
			freq_valid <= 1'b0;
			updated <= 1'b0;
		end else begin
			if (sgate && gate_d[0])
				quad <= {i_sign, i_sign ^ sdata[sample_w-1]};  // Sign pair, Gray to binary
			if (sqrt_en) begin
				quad_old <= quad;
				case (step)
					2'd1: quad_cnt <= quad_cnt - 1'b1;  // Clockwise
					2'd2: invalid <= 1'b1;              // Half turn, direction unknown
					2'd3: quad_cnt <= quad_cnt + 1'b1;  // Counter-clockwise
					default: ;
				endcase
			end
			if (window_end) begin
				freq_valid <= ~invalid;
				quad_cnt <= '0;
				invalid <= 1'b0;
			end
			updated <= window_end;
		end
	end

endmodule

/* complex_freq/isqrt.sv */
module isqrt #(
	parameter int x_width = cfreq_pkg::sq_w
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  cfreq_pkg::square_sum_t x,
	input  logic                   en,  // Ignored while a root is running
	output cfreq_pkg::amp_t        y,
	output logic                   dav
);

	localparam int n = x_width / 2;  // Result bits, one per step
	localparam int cnt_w = $clog2(n);
	localparam logic [cnt_w-1:0] last = cnt_w'(n - 1);

	cfreq_pkg::isqrt_state_t state;
	logic [cnt_w-1:0] count;
	logic [x_width-1:0] xs;  // Radicand, two bits consumed per step
	logic [n-1:0] rem;       // The final remainder is dropped, so n bits hold every live one
	logic [n-1:0] root;
	logic [n+1:0] rem_shift;
	logic [n+1:0] trial;
	logic [n-1:0] diff;
	logic fits;
	logic start;

	// Bring down the next bit pair and test root*4+1 against it
	assign rem_shift = {rem, xs[x_width-1 -: 2]};
	assign trial = {root, 2'b01};
	assign fits = rem_shift >= trial;
	assign diff = rem_shift[n-1:0] - trial[n-1:0];
	assign start = (state == cfreq_pkg::idle) && en;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= cfreq_pkg::idle;
			count <= '0;
			dav <= 1'b0;
		end else begin
			dav <= 1'b0;
			case (state)
				cfreq_pkg::idle: begin
					if (en) begin
						state <= cfreq_pkg::run;
						count <= '0;
					end
				end
				cfreq_pkg::run: begin
					count <= count + 1'b1;
					if (count == last) begin
						state <= cfreq_pkg::idle;
						dav <= 1'b1;  // 18 cycles after en
					end
				end
				default: state <= cfreq_pkg::idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			xs <= x;
			rem <= '0;
			root <= '0;
		end else if (state == cfreq_pkg::run) begin
			xs <= xs << 2;
			rem <= fits ? diff : rem_shift[n-1:0];
			root <= {root[n-2:0], fits};
			if (count == last)
				y <= {root[n-2:0], fits};
		end
	end

endmodule

/* source/iq_serializer.sv */
module iq_serializer (
	input  logic               clk,
	input  logic               rst_n,
	input  cfreq_pkg::sample_t sample_i,
	input  cfreq_pkg::sample_t sample_q,
	input  logic               sample_strobe,
	output cfreq_pkg::sample_t sdata,
	output logic               sgate
);

	cfreq_pkg::sample_t q_hold;  // Q waits one cycle behind I
	logic phase;                 // High while the Q word is due
	logic accept;

	// A strobe during the Q cycle would stretch the gate to three cycles
	assign accept = sample_strobe & ~phase;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sgate <= 1'b0;
			phase <= 1'b0;
		end else begin
			sgate <= accept | phase;  // I cycle, then Q cycle
			phase <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			sdata <= sample_i;
			q_hold <= sample_q;
		end else if (phase) begin
			sdata <= q_hold;
		end
	end

endmodule

/* common/cfreq_pkg.sv */
package cfreq_pkg;

	// Word widths on the sample path
	localparam int sample_w = 18;  // One I or Q word
	localparam int amp_w = 17;     // Magnitude, half the square-sum width
	localparam int sq_w = 34;      // Sum of squares after truncation

	// Signed baseband word, carried on I, Q and the serial bus
	typedef logic signed [sample_w-1:0] sample_t;

	// Magnitude and the min/max values built from it
	typedef logic [amp_w-1:0] amp_t;

	// Radicand for the square root
	typedef logic [sq_w-1:0] square_sum_t;

	// Square-root sequencer
	typedef enum logic {
		idle,
		run
	} isqrt_state_t;

endpackage
